//--- Makefile
# Verilator build and run of the decode stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f decode_stage.f \
		--top-module decode_stage_tb -Mdir obj_dir -o Vdecode_stage_tb

run: compile
	./obj_dir/Vdecode_stage_tb +verilator+error+limit+100000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- bench/decode_stage_props.sv
// --------------------
// Concurrent checks for the decode stage, bound into every instance
// of decode_stage. Covers the PC rules, the eat handshake, pass-through
// data, register fields, operand selection and the micro-op class flags.
// --------------------
`timescale 1ns/100ps

module decode_stage_props (
    input logic                     g_clk,
    input logic                     g_resetn,
    input logic                     s1_valid_i,
    input riscv_isa_pkg::instr_t    s1_instr_i,
    input logic                     s1_eat_4_o,
    input logic                     cf_valid_i,
    input logic                     cf_ack_i,
    input riscv_isa_pkg::xlen_t     cf_target_i,
    input riscv_isa_pkg::reg_addr_t s1_rs1_addr_o,
    input riscv_isa_pkg::reg_addr_t s1_rs2_addr_o,
    input riscv_isa_pkg::xlen_t     s1_rs1_data_i,
    input riscv_isa_pkg::xlen_t     s1_rs2_data_i,
    input logic                     s2_ready_i,
    input logic                     s2_valid_o,
    input riscv_isa_pkg::xlen_t     s2_pc_o,
    input riscv_isa_pkg::xlen_t     s2_npc_o,
    input riscv_isa_pkg::instr_t    s2_instr_o,
    input riscv_isa_pkg::xlen_t     s2_imm_o,
    input riscv_isa_pkg::reg_addr_t s2_rd_o,
    input riscv_isa_pkg::xlen_t     s2_rs1_data_o,
    input riscv_isa_pkg::xlen_t     s2_rs2_data_o,
    input riscv_isa_pkg::xlen_t     s2_alu_lhs_o,
    input riscv_isa_pkg::xlen_t     s2_alu_rhs_o,
    input decode_pipe_pkg::alu_op_t s2_alu_o,
    input decode_pipe_pkg::cfu_op_t s2_cfu_o,
    input decode_pipe_pkg::lsu_op_t s2_lsu_o,
    input decode_pipe_pkg::wb_sel_t s2_wb_o
);

    localparam riscv_isa_pkg::xlen_t RESET_PC = 64'h10000000;

    int                   err_count = 0;    // Read by the testbench
    logic [6:0]           opc;
    logic [2:0]           f3;
    logic                 redirect;
    logic                 is_branch;
    logic                 is_store;
    riscv_isa_pkg::xlen_t imm_i_exp;
    riscv_isa_pkg::xlen_t imm_b_exp;
    riscv_isa_pkg::xlen_t imm_u_exp;
    logic [7:0]           cfu_br_exp;

    task automatic flag_mismatch(input string what);
        err_count++;
        $error("Mismatch at %0t: %s", $time, what);
    endtask

    assign opc        = s1_instr_i[6:0];
    assign f3         = s1_instr_i[14:12];
    assign redirect   = cf_valid_i && cf_ack_i;
    assign is_branch  = opc == 7'b1100011;
    assign is_store   = opc == 7'b0100011;
    assign imm_i_exp  = {{52{s1_instr_i[31]}}, s1_instr_i[31:20]};
    assign imm_b_exp  = {{51{s1_instr_i[31]}}, s1_instr_i[31], s1_instr_i[7],
                         s1_instr_i[30:25], s1_instr_i[11:8], 1'b0};
    assign imm_u_exp  = {{32{s1_instr_i[31]}}, s1_instr_i[31:12], 12'b0};
    // One bit per branch funct3 and both jump bits clear
    assign cfu_br_exp = {f3 == 3'b000, f3 == 3'b001, f3 == 3'b100,
                         f3 == 3'b101, f3 == 3'b110, f3 == 3'b111, 2'b00};

    // --------------------
    // Program counter
    assert property (@(posedge g_clk) g_resetn && !$past(g_resetn) |-> s2_pc_o == RESET_PC)
        else flag_mismatch("s2_pc_o is not the reset address after reset");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_eat_4_o == (s1_valid_i && s2_ready_i))
        else flag_mismatch("s1_eat_4_o is not s1_valid_i and s2_ready_i");
    assert property (@(posedge g_clk) disable iff (!g_resetn) s2_npc_o == s2_pc_o + 64'd4)
        else flag_mismatch("s2_npc_o is not s2_pc_o plus 4");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(g_resetn) && $past(s1_eat_4_o) && !$past(redirect)
        |-> s2_pc_o == $past(s2_pc_o) + 64'd4)
        else flag_mismatch("s2_pc_o did not advance by 4 after an eat");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(g_resetn) && !$past(s1_eat_4_o) && !$past(redirect)
        |-> s2_pc_o == $past(s2_pc_o))
        else flag_mismatch("s2_pc_o moved without eat or redirect");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(g_resetn) && $past(redirect) |-> s2_pc_o == $past(cf_target_i))
        else flag_mismatch("s2_pc_o is not the redirect target");

    // --------------------
    // Pass-through to execute
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_valid_o == s1_valid_i && s2_instr_o == s1_instr_i &&
        s2_rs1_data_o == s1_rs1_data_i && s2_rs2_data_o == s1_rs2_data_i)
        else flag_mismatch("execute side pass-through");

    // --------------------
    // Register fields and operands
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_rs1_addr_o == s1_instr_i[19:15] && s1_rs2_addr_o == s1_instr_i[24:20] &&
        s2_rd_o == ((is_branch || is_store) ? 5'd0 : s1_instr_i[11:7]))
        else flag_mismatch("register address fields");
    // Shift immediates carry a shamt instead
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b0010011 && f3 != 3'b001 && f3 != 3'b101 |-> s2_alu_rhs_o == imm_i_exp)
        else flag_mismatch("OP-IMM right operand is not the I immediate");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b0110011 |-> s2_alu_rhs_o == s1_rs2_data_i)
        else flag_mismatch("OP right operand is not rs2 data");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b0010111 |-> s2_alu_rhs_o == imm_u_exp)
        else flag_mismatch("AUIPC right operand is not the U immediate");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_alu_lhs_o == ((opc == 7'b0010111) ? s2_pc_o : s1_rs1_data_i))
        else flag_mismatch("ALU left operand select");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        is_branch |-> s2_imm_o == imm_b_exp)
        else flag_mismatch("branch immediate");

    // --------------------
    // Class flags
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b0000011 |-> s2_lsu_o.load && s2_wb_o.lsu)
        else flag_mismatch("LOAD flags");
    // LB, LH and LW sign extend
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b0000011
        |-> s2_lsu_o.sext == (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b010))
        else flag_mismatch("LOAD sign extend flag");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        is_store |-> s2_lsu_o.store && s2_wb_o == 3'b000)
        else flag_mismatch("STORE flags");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        is_branch |-> s2_alu_o.sub && s2_cfu_o == cfu_br_exp && s2_wb_o == 3'b000)
        else flag_mismatch("BRANCH flags");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b1101111 || opc == 7'b1100111
        |-> s2_wb_o.npc && s2_cfu_o.jal == (opc == 7'b1101111)
            && s2_cfu_o.jalr == (opc == 7'b1100111))
        else flag_mismatch("JAL or JALR flags");
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        opc == 7'b0000011 || is_store
        |-> {s2_lsu_o.byte_w, s2_lsu_o.half_w, s2_lsu_o.word_w, s2_lsu_o.dbl_w}
            == (4'b1000 >> f3[1:0]))
        else flag_mismatch("load or store width bits");

endmodule

bind decode_stage decode_stage_props u_props (.*);

//--- bench/decode_stage_tb.sv
// --------------------
// Testbench top for the decode stage. Drives random but legal RV64
// instructions, handshakes and redirects into the DUT. The bound
// assertions do the checking, this module reports the outcome.
// --------------------
`timescale 1ns/100ps

module decode_stage_tb;

    localparam int RUN_CYCLES    = 400;
    localparam int RESET_CYCLES  = 5;
    localparam int CLK_PERIOD_NS = 10;
    localparam int WATCHDOG_NS   = (RUN_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD_NS * 2;

    logic                          g_clk;
    logic                          g_resetn;
    logic                          s1_valid_i;
    riscv_isa_pkg::instr_t         s1_instr_i;
    logic                          s1_eat_4_o;
    logic                          cf_valid_i;
    logic                          cf_ack_i;
    riscv_isa_pkg::xlen_t          cf_target_i;
    riscv_isa_pkg::reg_addr_t      s1_rs1_addr_o;
    riscv_isa_pkg::reg_addr_t      s1_rs2_addr_o;
    riscv_isa_pkg::xlen_t          s1_rs1_data_i;
    riscv_isa_pkg::xlen_t          s1_rs2_data_i;
    logic                          s2_ready_i;
    logic                          s2_valid_o;
    riscv_isa_pkg::xlen_t          s2_pc_o;
    riscv_isa_pkg::xlen_t          s2_npc_o;
    riscv_isa_pkg::instr_t         s2_instr_o;
    riscv_isa_pkg::xlen_t          s2_imm_o;
    riscv_isa_pkg::reg_addr_t      s2_rd_o;
    riscv_isa_pkg::xlen_t          s2_rs1_data_o;
    riscv_isa_pkg::xlen_t          s2_rs2_data_o;
    riscv_isa_pkg::xlen_t          s2_alu_lhs_o;
    riscv_isa_pkg::xlen_t          s2_alu_rhs_o;
    decode_pipe_pkg::alu_op_t      s2_alu_o;
    decode_pipe_pkg::cfu_op_t      s2_cfu_o;
    decode_pipe_pkg::lsu_op_t      s2_lsu_o;
    decode_pipe_pkg::wb_sel_t      s2_wb_o;

    logic [31:0] lcg_state = 32'd27;
    logic [31:0] rnd;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .g_clk_o    (g_clk),
        .g_resetn_o (g_resetn)
    );

    decode_stage u_dut (.*);

    // --------------------
    // Random source
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;      // Upper bits are the better ones
    endfunction

    // Random word shaped into a legal instruction of class cls
    function automatic riscv_isa_pkg::instr_t make_instr(input int cls, input logic [31:0] w);
        logic [31:0] ins;
        logic [2:0]  f3;
        logic        alt;
        ins = w;
        f3  = w[14:12];
        alt = w[30];
        case (cls)
            0: begin
                ins[6:0]   = 7'b0110011;            // OP
                ins[31:25] = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
            end
            1: begin
                ins[6:0] = 7'b0010011;              // OP-IMM
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    ins[31:26] = {1'b0, alt && f3 == 3'b101, 4'b0000};
                end
            end
            2, 3: begin
                ins[6:0]   = (cls == 2) ? 7'b0111011 : 7'b0011011;
                f3         = (w[13:12] == 2'd1) ? 3'b001 : (w[13:12] == 2'd2) ? 3'b101 : 3'b000;
                ins[31:25] = (alt && (f3 == 3'b101 || (cls == 2 && f3 == 3'b000))) ?
                             7'b0100000 : 7'b0;
            end
            4: ins[6:0] = 7'b0110111;               // LUI
            5: ins[6:0] = 7'b0010111;               // AUIPC
            6: ins[6:0] = 7'b1101111;               // JAL
            7: begin
                ins[6:0] = 7'b1100111;              // JALR
                f3       = 3'b000;
            end
            8: begin
                ins[6:0] = 7'b1100011;              // BRANCH
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;                   // Skip reserved 010 and 011
                end
            end
            9: begin
                ins[6:0] = 7'b0000011;              // LOAD
                if (f3 == 3'b111) begin
                    f3 = 3'b011;
                end
            end
            default: begin
                ins[6:0] = 7'b0100011;              // STORE
                f3[2]    = 1'b0;
            end
        endcase
        ins[14:12] = f3;
        return ins;
    endfunction

    task automatic print_summary(input int timeouts);
        $display("Summary: %0d assertion failures, %0d timeouts",
                 u_dut.u_props.err_count, timeouts);
    endtask

    // --------------------
    // Stimulus
    initial begin
        s1_valid_i    <= 1'b0;
        s1_instr_i    <= 32'h00000013;      // NOP
        cf_valid_i    <= 1'b0;
        cf_ack_i      <= 1'b0;
        cf_target_i   <= '0;
        s1_rs1_data_i <= '0;
        s1_rs2_data_i <= '0;
        s2_ready_i    <= 1'b0;
        @(posedge g_resetn);
        repeat (RUN_CYCLES) begin
            @(posedge g_clk);
            rnd = lcg_next();
            s1_instr_i    <= make_instr(pick_below(11), lcg_next());
            s1_valid_i    <= rnd[31:30] != 2'b00;           // Mostly valid
            s2_ready_i    <= rnd[29:28] != 2'b00;
            cf_valid_i    <= rnd[27:24] == 4'h0;            // Rare redirect
            cf_ack_i      <= rnd[23] || rnd[22];
            cf_target_i   <= {lcg_next(), lcg_next() & 32'hFFFF_FFFC};
            s1_rs1_data_i <= {lcg_next(), lcg_next()};
            s1_rs2_data_i <= {lcg_next(), lcg_next()};
        end
        repeat (3) @(posedge g_clk);
        #1;
        print_summary(0);
        if (u_dut.u_props.err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // --------------------
    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        print_summary(1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
// --------------------
// Testbench clock and reset source. Free running 10 ns g_clk and an
// active low synchronous reset held for RESET_CYCLES rising edges.
// --------------------
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic g_clk_o,
    output logic g_resetn_o
);

    initial begin
        g_clk_o    = 1'b0;
        g_resetn_o = 1'b0;
    end

    always #5 g_clk_o = ~g_clk_o;       // 10 ns period

    initial begin
        repeat (RESET_CYCLES) @(posedge g_clk_o);
        g_resetn_o <= 1'b1;
    end

endmodule

//--- decode_stage.f
source/riscv_isa_pkg.sv
source/decode_pipe_pkg.sv
source/decode_pc_tracker.sv
source/decode_uop_decoder.sv
source/decode_operands.sv
source/decode_stage.sv
bench/tb_clock_gen.sv
bench/decode_stage_props.sv
bench/decode_stage_tb.sv

//--- source/decode_operands.sv
// --------------------
// Builds the 64-bit immediate from the one-hot format select and
// picks the ALU left and right operands.
// --------------------
`timescale 1ns/100ps

module decode_operands (
    input  riscv_isa_pkg::instr_t     instr_i,
    input  decode_pipe_pkg::imm_fmt_t imm_fmt_i,
    input  logic                      use_pc_lhs_i,
    input  logic                      alu_rhs_imm_i,
    input  riscv_isa_pkg::xlen_t      pc_i,
    input  riscv_isa_pkg::xlen_t      rs1_data_i,
    input  riscv_isa_pkg::xlen_t      rs2_data_i,
    output riscv_isa_pkg::xlen_t      imm_o,
    output riscv_isa_pkg::xlen_t      alu_lhs_o,
    output riscv_isa_pkg::xlen_t      alu_rhs_o
);

    riscv_isa_pkg::imm32_t imm32_i, imm32_s, imm32_b, imm32_u, imm32_j;
    riscv_isa_pkg::imm32_t imm32;
    riscv_isa_pkg::xlen_t  imm_shamt;
    logic                  word_op;

    // --------------------
    // Raw immediates
    assign imm32_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm32_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm32_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
    assign imm32_u = {instr_i[31:12], 12'b0};
    assign imm32_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};

    // Word shifts only have a 5 bit amount
    assign word_op   = instr_i[6:0] == riscv_isa_pkg::OPC_OP_IMM_32;
    assign imm_shamt = word_op ? {59'b0, instr_i[24:20]} : {58'b0, instr_i[25:20]};

    always_comb begin
        imm32 = '0;
        if (imm_fmt_i.i) begin
            imm32 = imm32_i;
        end else if (imm_fmt_i.s) begin
            imm32 = imm32_s;
        end else if (imm_fmt_i.b) begin
            imm32 = imm32_b;
        end else if (imm_fmt_i.u) begin
            imm32 = imm32_u;
        end else if (imm_fmt_i.j) begin
            imm32 = imm32_j;
        end
    end

    assign imm_o = imm_fmt_i.shamt ? imm_shamt : {{32{imm32[31]}}, imm32};

    // --------------------
    // Operand muxes
    assign alu_lhs_o = use_pc_lhs_i  ? pc_i  : rs1_data_i;
    assign alu_rhs_o = alu_rhs_imm_i ? imm_o : rs2_data_i;

endmodule

//--- source/decode_pc_tracker.sv
// --------------------
// Program counter of the decode stage. Loads the reset address,
// follows control-flow redirects and advances by one instruction
// whenever execute takes the current one.
// --------------------
`timescale 1ns/100ps

module decode_pc_tracker #(
    parameter riscv_isa_pkg::xlen_t PC_RESET_ADDRESS = 64'h10000000
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,

    input  logic                 eat_i,         // Instruction consumed
    input  logic                 cf_valid_i,    // Control flow change
    input  logic                 cf_ack_i,      // Change accepted
    input  riscv_isa_pkg::xlen_t cf_target_i,   // Redirect address

    output riscv_isa_pkg::xlen_t pc_o,
    output riscv_isa_pkg::xlen_t npc_o
);

    logic                 redirect;
    riscv_isa_pkg::xlen_t pc_q;

    assign redirect = cf_valid_i && cf_ack_i;

    // Fixed 4 byte step
    assign npc_o = pc_q + riscv_isa_pkg::xlen_t'(riscv_isa_pkg::INSTR_BYTES);
    assign pc_o  = pc_q;

    // --------------------
    // PC register
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDRESS;
        end else if (redirect) begin
            pc_q <= cf_target_i;            // Redirect wins over advance
        end else if (eat_i) begin
            pc_q <= npc_o;
        end
    end

endmodule

//--- source/decode_pipe_pkg.sv
// --------------------
// Micro-op flag groups and decoded register fields passed from the
// decoder to the operand unit and on to execute.
// --------------------

package decode_pipe_pkg;

    typedef struct packed {
        logic add;
        logic and_op;
        logic or_op;
        logic sll;
        logic srl;
        logic slt;
        logic sltu;
        logic sra;
        logic sub;
        logic xor_op;
        logic word;         // 32-bit result, sign extended
    } alu_op_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic jal;
        logic jalr;
    } cfu_op_t;

    typedef struct packed {
        logic load;
        logic store;
        logic byte_w;
        logic half_w;
        logic word_w;
        logic dbl_w;
        logic sext;         // Sign extend loaded data
    } lsu_op_t;

    typedef struct packed {
        logic alu;
        logic lsu;
        logic npc;
    } wb_sel_t;

    // One-hot, all zero when no immediate is used
    typedef struct packed {
        logic i;
        logic s;
        logic b;
        logic u;
        logic j;
        logic shamt;
    } imm_fmt_t;

    typedef struct packed {
        riscv_isa_pkg::reg_addr_t rs1;
        riscv_isa_pkg::reg_addr_t rs2;
        riscv_isa_pkg::reg_addr_t rd;
    } reg_sel_t;

endpackage

//--- source/decode_stage.sv
// --------------------
// Decode and operand gather stage of the RV64 pipeline. Connects the
// PC tracker, micro-op decoder and operand unit between fetch, the
// register file and execute. One instruction in flight at a time.
// --------------------
`timescale 1ns/100ps

module decode_stage #(
    parameter riscv_isa_pkg::xlen_t PC_RESET_ADDRESS = 64'h10000000
) (
    input  logic                         g_clk,
    input  logic                         g_resetn,

    input  logic                         s1_valid_i,      // Fetch has an instruction
    input  riscv_isa_pkg::instr_t        s1_instr_i,
    output logic                         s1_eat_4_o,      // Instruction consumed

    input  logic                         cf_valid_i,
    input  logic                         cf_ack_i,
    input  riscv_isa_pkg::xlen_t         cf_target_i,

    output riscv_isa_pkg::reg_addr_t     s1_rs1_addr_o,
    input  riscv_isa_pkg::xlen_t         s1_rs1_data_i,   // Forwarded read data
    output riscv_isa_pkg::reg_addr_t     s1_rs2_addr_o,
    input  riscv_isa_pkg::xlen_t         s1_rs2_data_i,

    input  logic                         s2_ready_i,
    output logic                         s2_valid_o,
    output riscv_isa_pkg::xlen_t         s2_pc_o,
    output riscv_isa_pkg::xlen_t         s2_npc_o,
    output riscv_isa_pkg::instr_t        s2_instr_o,
    output riscv_isa_pkg::xlen_t         s2_imm_o,
    output riscv_isa_pkg::reg_addr_t     s2_rd_o,
    output riscv_isa_pkg::xlen_t         s2_rs1_data_o,
    output riscv_isa_pkg::xlen_t         s2_rs2_data_o,
    output riscv_isa_pkg::xlen_t         s2_alu_lhs_o,
    output riscv_isa_pkg::xlen_t         s2_alu_rhs_o,
    output decode_pipe_pkg::alu_op_t     s2_alu_o,
    output decode_pipe_pkg::cfu_op_t     s2_cfu_o,
    output decode_pipe_pkg::lsu_op_t     s2_lsu_o,
    output decode_pipe_pkg::wb_sel_t     s2_wb_o
);

    decode_pipe_pkg::reg_sel_t regs;
    decode_pipe_pkg::imm_fmt_t imm_fmt;
    logic                      use_pc_lhs;
    logic                      alu_rhs_imm;

    // --------------------
    // Stage progression
    assign s1_eat_4_o    = s1_valid_i && s2_ready_i;
    assign s2_valid_o    = s1_valid_i;
    assign s2_instr_o    = s1_instr_i;
    assign s1_rs1_addr_o = regs.rs1;
    assign s1_rs2_addr_o = regs.rs2;
    assign s2_rd_o       = regs.rd;
    assign s2_rs1_data_o = s1_rs1_data_i;
    assign s2_rs2_data_o = s1_rs2_data_i;

    decode_pc_tracker #(
        .PC_RESET_ADDRESS (PC_RESET_ADDRESS)
    ) u_pc (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .eat_i       (s1_eat_4_o),
        .cf_valid_i  (cf_valid_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .pc_o        (s2_pc_o),
        .npc_o       (s2_npc_o)
    );

    decode_uop_decoder u_dec (
        .instr_i       (s1_instr_i),
        .regs_o        (regs),
        .imm_fmt_o     (imm_fmt),
        .use_pc_lhs_o  (use_pc_lhs),
        .alu_rhs_imm_o (alu_rhs_imm),
        .alu_o         (s2_alu_o),
        .cfu_o         (s2_cfu_o),
        .lsu_o         (s2_lsu_o),
        .wb_o          (s2_wb_o)
    );

    decode_operands u_ops (
        .instr_i       (s1_instr_i),
        .imm_fmt_i     (imm_fmt),
        .use_pc_lhs_i  (use_pc_lhs),
        .alu_rhs_imm_i (alu_rhs_imm),
        .pc_i          (s2_pc_o),
        .rs1_data_i    (s1_rs1_data_i),
        .rs2_data_i    (s1_rs2_data_i),
        .imm_o         (s2_imm_o),
        .alu_lhs_o     (s2_alu_lhs_o),
        .alu_rhs_o     (s2_alu_rhs_o)
    );

endmodule

//--- source/decode_uop_decoder.sv
// --------------------
// Decodes a 32-bit instruction into register fields, an immediate
// format select and the ALU, CFU, LSU and writeback micro-op flags.
// Purely combinational.
// --------------------
`timescale 1ns/100ps

module decode_uop_decoder (
    input  riscv_isa_pkg::instr_t     instr_i,
    output decode_pipe_pkg::reg_sel_t regs_o,
    output decode_pipe_pkg::imm_fmt_t imm_fmt_o,
    output logic                      use_pc_lhs_o,     // AUIPC
    output logic                      alu_rhs_imm_o,    // Immediate as rhs
    output decode_pipe_pkg::alu_op_t  alu_o,
    output decode_pipe_pkg::cfu_op_t  cfu_o,
    output decode_pipe_pkg::lsu_op_t  lsu_o,
    output decode_pipe_pkg::wb_sel_t  wb_o
);

    riscv_isa_pkg::opcode_t   opcode;
    riscv_isa_pkg::funct3_t   funct3;
    riscv_isa_pkg::funct7_t   funct7;
    logic op_reg, op_imm, op_lui, op_auipc, op_jal, op_jalr;
    logic op_branch, op_load, op_store, op_ls, is_alu, alt, shift_imm;
    decode_pipe_pkg::alu_op_t alu;
    decode_pipe_pkg::cfu_op_t cfu;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // --------------------
    // Opcode classes
    assign op_reg    = opcode == riscv_isa_pkg::OPC_OP || opcode == riscv_isa_pkg::OPC_OP_32;
    assign op_imm    = opcode == riscv_isa_pkg::OPC_OP_IMM ||
                       opcode == riscv_isa_pkg::OPC_OP_IMM_32;
    assign op_lui    = opcode == riscv_isa_pkg::OPC_LUI;
    assign op_auipc  = opcode == riscv_isa_pkg::OPC_AUIPC;
    assign op_jal    = opcode == riscv_isa_pkg::OPC_JAL;
    assign op_jalr   = opcode == riscv_isa_pkg::OPC_JALR;
    assign op_branch = opcode == riscv_isa_pkg::OPC_BRANCH;
    assign op_load   = opcode == riscv_isa_pkg::OPC_LOAD;
    assign op_store  = opcode == riscv_isa_pkg::OPC_STORE;
    assign op_ls     = op_load || op_store;
    assign is_alu    = op_reg || op_imm;

    // SUB/SRA select, immediate shifts carry it in imm bit 30
    assign alt       = op_reg ? (funct7 == riscv_isa_pkg::F7_ALT) : instr_i[30];
    assign shift_imm = op_imm && (funct3 == riscv_isa_pkg::F3_SLL ||
                                  funct3 == riscv_isa_pkg::F3_SR);

    assign regs_o.rs1 = instr_i[19:15];
    assign regs_o.rs2 = instr_i[24:20];
    assign regs_o.rd  = (op_branch || op_store) ? '0 : instr_i[11:7];

    assign imm_fmt_o.i     = (op_imm && !shift_imm) || op_jalr || op_load;
    assign imm_fmt_o.s     = op_store;
    assign imm_fmt_o.b     = op_branch;
    assign imm_fmt_o.u     = op_lui || op_auipc;
    assign imm_fmt_o.j     = op_jal;
    assign imm_fmt_o.shamt = shift_imm;

    assign use_pc_lhs_o  = op_auipc;
    assign alu_rhs_imm_o = op_imm || op_lui || op_auipc;

    // --------------------
    // ALU and CFU flags
    always_comb begin
        alu        = '0;
        alu.word   = opcode == riscv_isa_pkg::OPC_OP_32 ||
                     opcode == riscv_isa_pkg::OPC_OP_IMM_32;
        alu.add    = op_auipc;
        alu.or_op  = op_lui;                // rhs carries the U immediate
        alu.sub    = op_branch;             // Compare by subtraction
        if (is_alu) begin
            case (funct3)
                riscv_isa_pkg::F3_ADD: begin
                    alu.add = !(op_reg && alt);
                    alu.sub = op_reg && alt;
                end
                riscv_isa_pkg::F3_SLL:  alu.sll    = 1'b1;
                riscv_isa_pkg::F3_SLT:  alu.slt    = 1'b1;
                riscv_isa_pkg::F3_SLTU: alu.sltu   = 1'b1;
                riscv_isa_pkg::F3_XOR:  alu.xor_op = 1'b1;
                riscv_isa_pkg::F3_SR: begin
                    alu.srl = !alt;
                    alu.sra = alt;
                end
                riscv_isa_pkg::F3_OR:   alu.or_op  = 1'b1;
                riscv_isa_pkg::F3_AND:  alu.and_op = 1'b1;
            endcase
        end
    end

    always_comb begin
        cfu      = '0;
        cfu.jal  = op_jal;
        cfu.jalr = op_jalr;
        if (op_branch) begin
            case (funct3)
                riscv_isa_pkg::F3_BEQ:  cfu.beq  = 1'b1;
                riscv_isa_pkg::F3_BNE:  cfu.bne  = 1'b1;
                riscv_isa_pkg::F3_BLT:  cfu.blt  = 1'b1;
                riscv_isa_pkg::F3_BGE:  cfu.bge  = 1'b1;
                riscv_isa_pkg::F3_BLTU: cfu.bltu = 1'b1;
                riscv_isa_pkg::F3_BGEU: cfu.bgeu = 1'b1;
                default:                cfu      = '0;     // Reserved encodings
            endcase
        end
    end

    assign alu_o = alu;
    assign cfu_o = cfu;

    // --------------------
    // LSU and writeback
    assign lsu_o.load   = op_load;
    assign lsu_o.store  = op_store;
    assign lsu_o.byte_w = op_ls && funct3[1:0] == riscv_isa_pkg::LS_BYTE;
    assign lsu_o.half_w = op_ls && funct3[1:0] == riscv_isa_pkg::LS_HALF;
    assign lsu_o.word_w = op_ls && funct3[1:0] == riscv_isa_pkg::LS_WORD;
    assign lsu_o.dbl_w  = op_ls && funct3[1:0] == riscv_isa_pkg::LS_DBL;
    assign lsu_o.sext   = op_load && !funct3[2] && funct3[1:0] != riscv_isa_pkg::LS_DBL;

    assign wb_o.npc = op_jal || op_jalr;
    assign wb_o.lsu = op_load;
    assign wb_o.alu = (|alu) && !op_branch && !(op_jal || op_jalr);

endmodule

//--- source/riscv_isa_pkg.sv
// --------------------
// RV64 base-integer ISA definitions shared by the decode stage.
// Word, instruction and register index types, major opcodes and
// funct3 codes. Referenced by scoped name only.
// --------------------

package riscv_isa_pkg;

    typedef logic [63:0] xlen_t;        // Machine word
    typedef logic [31:0] instr_t;       // Instruction word
    typedef logic [4:0]  reg_addr_t;    // GPR index
    typedef logic [31:0] imm32_t;       // Raw immediate before sext
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    parameter int INSTR_BYTES = 4;      // No compressed forms

    // --------------------
    // Major opcodes
    parameter opcode_t OPC_OP        = 7'b0110011;
    parameter opcode_t OPC_OP_IMM    = 7'b0010011;
    parameter opcode_t OPC_OP_32     = 7'b0111011;
    parameter opcode_t OPC_OP_IMM_32 = 7'b0011011;
    parameter opcode_t OPC_LUI       = 7'b0110111;
    parameter opcode_t OPC_AUIPC     = 7'b0010111;
    parameter opcode_t OPC_JAL       = 7'b1101111;
    parameter opcode_t OPC_JALR      = 7'b1100111;
    parameter opcode_t OPC_BRANCH    = 7'b1100011;
    parameter opcode_t OPC_LOAD      = 7'b0000011;
    parameter opcode_t OPC_STORE     = 7'b0100011;

    // --------------------
    // funct3 / funct7 codes
    parameter funct3_t F3_ADD  = 3'b000;    // ADD, SUB, ADDI
    parameter funct3_t F3_SLL  = 3'b001;
    parameter funct3_t F3_SLT  = 3'b010;
    parameter funct3_t F3_SLTU = 3'b011;
    parameter funct3_t F3_XOR  = 3'b100;
    parameter funct3_t F3_SR   = 3'b101;    // SRL and SRA
    parameter funct3_t F3_OR   = 3'b110;
    parameter funct3_t F3_AND  = 3'b111;

    parameter funct3_t F3_BEQ  = 3'b000;
    parameter funct3_t F3_BNE  = 3'b001;
    parameter funct3_t F3_BLT  = 3'b100;
    parameter funct3_t F3_BGE  = 3'b101;
    parameter funct3_t F3_BLTU = 3'b110;
    parameter funct3_t F3_BGEU = 3'b111;

    parameter funct7_t F7_ALT  = 7'b0100000; // SUB, SRA
    parameter logic [1:0] LS_BYTE = 2'b00;   // Access size in funct3[1:0]
    parameter logic [1:0] LS_HALF = 2'b01;
    parameter logic [1:0] LS_WORD = 2'b10;
    parameter logic [1:0] LS_DBL  = 2'b11;

endpackage
